// File: src.f
+incdir+.
llc_chan_pkg.sv
skid_control.sv
skid_buffer.sv
llc_channel_boundary.sv
tb_llc_channel_boundary.sv

// File: Bender.yml
package:
  name: llc_channel_boundary

sources:
  - llc_chan_pkg.sv
  - skid_control.sv
  - skid_buffer.sv
  - llc_channel_boundary.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_llc_channel_boundary.sv

// File: tb_llc_checks.svh
`ifndef TB_LLC_CHECKS_SVH
`define TB_LLC_CHECKS_SVH

function automatic int chan_width(input int ch);
    case (ch)
        0, 1:    return REQ_IN_W;
        2:       return RSP_IN_W;
        3:       return MEM_RSP_W;
        4, 5:    return RSP_OUT_W;
        6:       return FWD_OUT_W;
        default: return MEM_REQ_W;
    endcase
endfunction

// Expected message, bits above the channel width stay zero
function automatic wide_t make_payload(input int ch, input int idx);
    logic [191:0] raw;
    logic [31:0]  c;
    logic [31:0]  n;
    wide_t        v;
    int           k;
    c = ch + 1;
    n = idx;
    for (k = 0; k < 6; k++) begin
        raw[k*32 +: 32] = (c * 32'h9E37_79B1) ^ (n * 32'h85EB_CA6B)
                        ^ ((k + 1) * 32'hC2B2_AE35) ^ (n << k);
    end
    v = raw[MAX_W-1:0];
    for (k = chan_width(ch); k < MAX_W; k++) begin
        v[k] = 1'b0;
    end
    return v;
endfunction

task automatic report_data_error(input int ch, input int idx, input wide_t got, input wide_t exp);
    $display("Error at %0t: channel %0d item %0d data %h, expected %h",
             $time, ch, idx, got, exp);
    abort_run();
endtask

task automatic compare_flag(input logic got, input logic exp, input int ch, input string what);
    if (got !== exp) begin
        $display("Error at %0t: channel %0d %s is %b, expected %b", $time, ch, what, got, exp);
        abort_run();
    end
endtask

task automatic compare_req_in(input req_in_payload_t got, exp, input int ch, idx);
    if (got !== exp) report_data_error(ch, idx, got, exp);
endtask

task automatic compare_rsp_in(input rsp_in_payload_t got, exp, input int ch, idx);
    if (got !== exp) report_data_error(ch, idx, got, exp);
endtask

task automatic compare_mem_rsp(input mem_rsp_payload_t got, exp, input int ch, idx);
    if (got !== exp) report_data_error(ch, idx, got, exp);
endtask

task automatic compare_rsp_out(input rsp_out_payload_t got, exp, input int ch, idx);
    if (got !== exp) report_data_error(ch, idx, got, exp);
endtask

task automatic compare_fwd_out(input fwd_out_payload_t got, exp, input int ch, idx);
    if (got !== exp) report_data_error(ch, idx, got, exp);
endtask

task automatic compare_mem_req(input mem_req_payload_t got, exp, input int ch, idx);
    if (got !== exp) report_data_error(ch, idx, got, exp);
endtask

`endif

// File: tb_llc_channel_boundary.sv
`timescale 1ns/100ps

module tb_llc_channel_boundary;
    import llc_chan_pkg::*;

    localparam int CHANNELS = 8;
    localparam int ITEMS    = 200;
    localparam int MAX_W    = RSP_OUT_W;
    // Roughly four cycles per transfer, times a margin of 25
    localparam int TIMEOUT_CYCLES = ITEMS * 4 * 25;

    typedef logic [MAX_W-1:0] wide_t;

    logic                           clk;
    logic                           rst;
    logic [CHANNELS-1:0]            valid_in;
    logic [CHANNELS-1:0]            ready_in;
    logic [CHANNELS-1:0][MAX_W-1:0] data_in;
    wire  [CHANNELS-1:0]            valid_out;
    wire  [CHANNELS-1:0]            ready_out;
    wire  [CHANNELS-1:0][MAX_W-1:0] data_out;

    int                  seed;
    int                  cycles;
    int                  drain;
    int                  sent_count [CHANNELS];
    int                  rcv_count  [CHANNELS];
    logic [CHANNELS-1:0] exp_held;
    logic [CHANNELS-1:0] in_fire;

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1);
    endtask

    `include "tb_llc_checks.svh"

    // Channel numbers: 0 req_in, 1 dma_req_in, 2 rsp_in, 3 mem_rsp,
    // 4 rsp_out, 5 dma_rsp_out, 6 fwd_out, 7 mem_req
    llc_channel_boundary dut (
        .clk                 (clk),
        .rst                 (rst),
        .req_in_valid_i      (valid_in[0]),
        .req_in_ready_o      (ready_out[0]),
        .req_in_data_i       (data_in[0][REQ_IN_W-1:0]),
        .req_in_valid_o      (valid_out[0]),
        .req_in_ready_i      (ready_in[0]),
        .req_in_data_o       (data_out[0][REQ_IN_W-1:0]),
        .dma_req_in_valid_i  (valid_in[1]),
        .dma_req_in_ready_o  (ready_out[1]),
        .dma_req_in_data_i   (data_in[1][REQ_IN_W-1:0]),
        .dma_req_in_valid_o  (valid_out[1]),
        .dma_req_in_ready_i  (ready_in[1]),
        .dma_req_in_data_o   (data_out[1][REQ_IN_W-1:0]),
        .rsp_in_valid_i      (valid_in[2]),
        .rsp_in_ready_o      (ready_out[2]),
        .rsp_in_data_i       (data_in[2][RSP_IN_W-1:0]),
        .rsp_in_valid_o      (valid_out[2]),
        .rsp_in_ready_i      (ready_in[2]),
        .rsp_in_data_o       (data_out[2][RSP_IN_W-1:0]),
        .mem_rsp_valid_i     (valid_in[3]),
        .mem_rsp_ready_o     (ready_out[3]),
        .mem_rsp_data_i      (data_in[3][MEM_RSP_W-1:0]),
        .mem_rsp_valid_o     (valid_out[3]),
        .mem_rsp_ready_i     (ready_in[3]),
        .mem_rsp_data_o      (data_out[3][MEM_RSP_W-1:0]),
        .rsp_out_valid_i     (valid_in[4]),
        .rsp_out_ready_o     (ready_out[4]),
        .rsp_out_data_i      (data_in[4][RSP_OUT_W-1:0]),
        .rsp_out_valid_o     (valid_out[4]),
        .rsp_out_ready_i     (ready_in[4]),
        .rsp_out_data_o      (data_out[4][RSP_OUT_W-1:0]),
        .dma_rsp_out_valid_i (valid_in[5]),
        .dma_rsp_out_ready_o (ready_out[5]),
        .dma_rsp_out_data_i  (data_in[5][RSP_OUT_W-1:0]),
        .dma_rsp_out_valid_o (valid_out[5]),
        .dma_rsp_out_ready_i (ready_in[5]),
        .dma_rsp_out_data_o  (data_out[5][RSP_OUT_W-1:0]),
        .fwd_out_valid_i     (valid_in[6]),
        .fwd_out_ready_o     (ready_out[6]),
        .fwd_out_data_i      (data_in[6][FWD_OUT_W-1:0]),
        .fwd_out_valid_o     (valid_out[6]),
        .fwd_out_ready_i     (ready_in[6]),
        .fwd_out_data_o      (data_out[6][FWD_OUT_W-1:0]),
        .mem_req_valid_i     (valid_in[7]),
        .mem_req_ready_o     (ready_out[7]),
        .mem_req_data_i      (data_in[7][MEM_REQ_W-1:0]),
        .mem_req_valid_o     (valid_out[7]),
        .mem_req_ready_i     (ready_in[7]),
        .mem_req_data_o      (data_out[7][MEM_REQ_W-1:0])
    );

    always #2 clk = ~clk;

    task automatic compare_payload(input int ch, input int idx, input wide_t got);
        wide_t exp;
        exp = make_payload(ch, idx);
        case (ch)
            0, 1:    compare_req_in(got[REQ_IN_W-1:0], exp[REQ_IN_W-1:0], ch, idx);
            2:       compare_rsp_in(got[RSP_IN_W-1:0], exp[RSP_IN_W-1:0], ch, idx);
            3:       compare_mem_rsp(got[MEM_RSP_W-1:0], exp[MEM_RSP_W-1:0], ch, idx);
            4, 5:    compare_rsp_out(got[RSP_OUT_W-1:0], exp[RSP_OUT_W-1:0], ch, idx);
            6:       compare_fwd_out(got[FWD_OUT_W-1:0], exp[FWD_OUT_W-1:0], ch, idx);
            default: compare_mem_req(got[MEM_REQ_W-1:0], exp[MEM_REQ_W-1:0], ch, idx);
        endcase
    endtask

    // Runs 1 ns after the rising edge
    task automatic drive_inputs();
        for (int ch = 0; ch < CHANNELS; ch++) begin
            if (in_fire[ch]) begin
                valid_in[ch] = 1'b0;
            end
            if (!valid_in[ch] && sent_count[ch] < ITEMS && ($random(seed) & 3) != 0) begin
                valid_in[ch] = 1'b1;
                data_in[ch]  = make_payload(ch, sent_count[ch]);
            end
            ready_in[ch] = $random(seed) & 1;
        end
    endtask

    // Runs on the falling edge, sees what the next rising edge will transfer
    task automatic check_channels();
        for (int ch = 0; ch < CHANNELS; ch++) begin
            compare_flag(ready_out[ch], !exp_held[ch], ch, "ready_o");
            compare_flag(valid_out[ch], valid_in[ch] || exp_held[ch], ch, "valid_o");
            // Offered data is always the next message in order, held or passed through
            if (valid_out[ch]) begin
                compare_payload(ch, rcv_count[ch], data_out[ch]);
                if (ready_in[ch]) begin
                    rcv_count[ch]++;
                end
            end
            in_fire[ch] = valid_in[ch] && ready_out[ch];
            if (in_fire[ch]) begin
                sent_count[ch]++;
            end
            exp_held[ch] = exp_held[ch] ? !ready_in[ch] : (in_fire[ch] && !ready_in[ch]);
        end
    endtask

    function automatic bit all_received();
        for (int ch = 0; ch < CHANNELS; ch++) begin
            if (rcv_count[ch] != ITEMS) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    initial begin : timeout
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, some channel never finished its traffic", cycles);
        abort_run();
    end

    initial begin : main
        seed     = 63005;
        clk      = 1'b0;
        rst      = 1'b0;
        valid_in = '0;
        ready_in = '0;
        data_in  = '0;
        exp_held = '0;
        in_fire  = '0;
        for (int ch = 0; ch < CHANNELS; ch++) begin
            sent_count[ch] = 0;
            rcv_count[ch]  = 0;
        end
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b1;

        // Idle after reset
        @(negedge clk);
        for (int ch = 0; ch < CHANNELS; ch++) begin
            compare_flag(valid_out[ch], 1'b0, ch, "valid_o");
            compare_flag(ready_out[ch], 1'b1, ch, "ready_o");
        end

        // Idle cycles after the last transfer catch a repeated or extra message
        drain = 2;
        while (drain > 0) begin
            @(posedge clk);
            #1;
            drive_inputs();
            @(negedge clk);
            check_channels();
            if (all_received()) begin
                drain--;
            end
        end

        $display("TEST OK");
        $finish;
    end

endmodule

// File: llc_channel_boundary.sv
`timescale 1ns/100ps

module llc_channel_boundary (
    input  logic                           clk,
    input  logic                           rst,

    // Cache requests, outside to core
    input  logic                           req_in_valid_i,
    output logic                           req_in_ready_o,
    input  llc_chan_pkg::req_in_payload_t  req_in_data_i,
    output logic                           req_in_valid_o,
    input  logic                           req_in_ready_i,
    output llc_chan_pkg::req_in_payload_t  req_in_data_o,

    // DMA requests, outside to core
    input  logic                           dma_req_in_valid_i,
    output logic                           dma_req_in_ready_o,
    input  llc_chan_pkg::req_in_payload_t  dma_req_in_data_i,
    output logic                           dma_req_in_valid_o,
    input  logic                           dma_req_in_ready_i,
    output llc_chan_pkg::req_in_payload_t  dma_req_in_data_o,

    // Coherence responses, outside to core
    input  logic                           rsp_in_valid_i,
    output logic                           rsp_in_ready_o,
    input  llc_chan_pkg::rsp_in_payload_t  rsp_in_data_i,
    output logic                           rsp_in_valid_o,
    input  logic                           rsp_in_ready_i,
    output llc_chan_pkg::rsp_in_payload_t  rsp_in_data_o,

    // Memory responses, outside to core
    input  logic                           mem_rsp_valid_i,
    output logic                           mem_rsp_ready_o,
    input  llc_chan_pkg::mem_rsp_payload_t mem_rsp_data_i,
    output logic                           mem_rsp_valid_o,
    input  logic                           mem_rsp_ready_i,
    output llc_chan_pkg::mem_rsp_payload_t mem_rsp_data_o,

    // Cache responses, core to outside
    input  logic                           rsp_out_valid_i,
    output logic                           rsp_out_ready_o,
    input  llc_chan_pkg::rsp_out_payload_t rsp_out_data_i,
    output logic                           rsp_out_valid_o,
    input  logic                           rsp_out_ready_i,
    output llc_chan_pkg::rsp_out_payload_t rsp_out_data_o,

    // DMA responses, core to outside
    input  logic                           dma_rsp_out_valid_i,
    output logic                           dma_rsp_out_ready_o,
    input  llc_chan_pkg::rsp_out_payload_t dma_rsp_out_data_i,
    output logic                           dma_rsp_out_valid_o,
    input  logic                           dma_rsp_out_ready_i,
    output llc_chan_pkg::rsp_out_payload_t dma_rsp_out_data_o,

    // Forwards, core to outside
    input  logic                           fwd_out_valid_i,
    output logic                           fwd_out_ready_o,
    input  llc_chan_pkg::fwd_out_payload_t fwd_out_data_i,
    output logic                           fwd_out_valid_o,
    input  logic                           fwd_out_ready_i,
    output llc_chan_pkg::fwd_out_payload_t fwd_out_data_o,

    // Memory requests, core to outside
    input  logic                           mem_req_valid_i,
    output logic                           mem_req_ready_o,
    input  llc_chan_pkg::mem_req_payload_t mem_req_data_i,
    output logic                           mem_req_valid_o,
    input  logic                           mem_req_ready_i,
    output llc_chan_pkg::mem_req_payload_t mem_req_data_o
);
    import llc_chan_pkg::*;

    // Inbound channels
    skid_buffer #(
        .WIDTH (REQ_IN_W)
    ) req_in (
        .clk     (clk),
        .rst     (rst),
        .valid_i (req_in_valid_i),
        .ready_i (req_in_ready_i),
        .data_i  (req_in_data_i),
        .ready_o (req_in_ready_o),
        .valid_o (req_in_valid_o),
        .data_o  (req_in_data_o)
    );

    skid_buffer #(
        .WIDTH (REQ_IN_W)
    ) dma_req_in (
        .clk     (clk),
        .rst     (rst),
        .valid_i (dma_req_in_valid_i),
        .ready_i (dma_req_in_ready_i),
        .data_i  (dma_req_in_data_i),
        .ready_o (dma_req_in_ready_o),
        .valid_o (dma_req_in_valid_o),
        .data_o  (dma_req_in_data_o)
    );

    skid_buffer #(
        .WIDTH (RSP_IN_W)
    ) rsp_in (
        .clk     (clk),
        .rst     (rst),
        .valid_i (rsp_in_valid_i),
        .ready_i (rsp_in_ready_i),
        .data_i  (rsp_in_data_i),
        .ready_o (rsp_in_ready_o),
        .valid_o (rsp_in_valid_o),
        .data_o  (rsp_in_data_o)
    );

    skid_buffer #(
        .WIDTH (MEM_RSP_W)
    ) mem_rsp (
        .clk     (clk),
        .rst     (rst),
        .valid_i (mem_rsp_valid_i),
        .ready_i (mem_rsp_ready_i),
        .data_i  (mem_rsp_data_i),
        .ready_o (mem_rsp_ready_o),
        .valid_o (mem_rsp_valid_o),
        .data_o  (mem_rsp_data_o)
    );

    // Outbound channels
    skid_buffer #(
        .WIDTH (RSP_OUT_W)
    ) rsp_out (
        .clk     (clk),
        .rst     (rst),
        .valid_i (rsp_out_valid_i),
        .ready_i (rsp_out_ready_i),
        .data_i  (rsp_out_data_i),
        .ready_o (rsp_out_ready_o),
        .valid_o (rsp_out_valid_o),
        .data_o  (rsp_out_data_o)
    );

    skid_buffer #(
        .WIDTH (RSP_OUT_W)
    ) dma_rsp_out (
        .clk     (clk),
        .rst     (rst),
        .valid_i (dma_rsp_out_valid_i),
        .ready_i (dma_rsp_out_ready_i),
        .data_i  (dma_rsp_out_data_i),
        .ready_o (dma_rsp_out_ready_o),
        .valid_o (dma_rsp_out_valid_o),
        .data_o  (dma_rsp_out_data_o)
    );

    skid_buffer #(
        .WIDTH (FWD_OUT_W)
    ) fwd_out (
        .clk     (clk),
        .rst     (rst),
        .valid_i (fwd_out_valid_i),
        .ready_i (fwd_out_ready_i),
        .data_i  (fwd_out_data_i),
        .ready_o (fwd_out_ready_o),
        .valid_o (fwd_out_valid_o),
        .data_o  (fwd_out_data_o)
    );

    skid_buffer #(
        .WIDTH (MEM_REQ_W)
    ) mem_req (
        .clk     (clk),
        .rst     (rst),
        .valid_i (mem_req_valid_i),
        .ready_i (mem_req_ready_i),
        .data_i  (mem_req_data_i),
        .ready_o (mem_req_ready_o),
        .valid_o (mem_req_valid_o),
        .data_o  (mem_req_data_o)
    );

endmodule

// File: skid_buffer.sv
`timescale 1ns/100ps

module skid_buffer #(
    parameter int WIDTH = llc_chan_pkg::REQ_IN_W
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             valid_i,
    input  logic             ready_i,
    input  logic [WIDTH-1:0] data_i,
    output logic             ready_o,
    output logic             valid_o,
    output logic [WIDTH-1:0] data_o
);

    logic             capture;
    logic             held;
    logic [WIDTH-1:0] data_held;

    skid_control ctrl (
        .clk       (clk),
        .rst       (rst),
        .valid_i   (valid_i),
        .ready_i   (ready_i),
        .ready_o   (ready_o),
        .valid_o   (valid_o),
        .capture_o (capture),
        .held_o    (held)
    );

    // One entry of payload storage
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            data_held <= '0;
        end else if (capture) begin
            data_held <= data_i;
        end
    end

    // Bypass while empty
    assign data_o = held ? data_held : data_i;

    // Offered payload must not change under back-pressure
    a_data_stable: assert property (
        @(posedge clk) disable iff (!rst)
        (valid_o && !ready_i) |=> $stable(data_o));

endmodule

// File: skid_control.sv
`timescale 1ns/100ps

module skid_control (
    input  logic clk,
    input  logic rst,
    input  logic valid_i,
    input  logic ready_i,
    output logic ready_o,
    output logic valid_o,
    output logic capture_o,
    output logic held_o
);
    import llc_chan_pkg::*;

    skid_state_t state;
    skid_state_t state_next;

    assign held_o    = (state == SKID_HELD);
    assign ready_o   = !held_o;
    assign valid_o   = valid_i || held_o;
    // Sender accepted but receiver stalled
    assign capture_o = (state == SKID_EMPTY) && valid_i && !ready_i;

    always_comb begin
        state_next = state;
        case (state)
            SKID_EMPTY: begin
                if (capture_o) begin
                    state_next = SKID_HELD;
                end
            end
            SKID_HELD: begin
                if (ready_i) begin
                    state_next = SKID_EMPTY;
                end
            end
            default: state_next = SKID_EMPTY;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= SKID_EMPTY;
        end else begin
            state <= state_next;
        end
    end

    // Stalled sender keeps its message offered
    a_sender_holds_valid: assert property (
        @(posedge clk) disable iff (!rst)
        (valid_i && !ready_o) |=> valid_i);

    // Offered message stays valid until the receiver takes it
    a_held_valid_stable: assert property (
        @(posedge clk) disable iff (!rst)
        (valid_o && !ready_i) |=> valid_o);

endmodule

// File: llc_chan_pkg.sv
package llc_chan_pkg;

    // Message field widths
    localparam int COH_MSG_W     = 3;
    localparam int HPROT_W       = 1;
    localparam int LINE_ADDR_W   = 28;
    localparam int LINE_W        = 128;
    localparam int CACHE_ID_W    = 4;
    localparam int WORD_OFFSET_W = 2;
    localparam int WORD_MASK_W   = 2;
    localparam int INVACK_CNT_W  = 4;
    localparam int HSIZE_W       = 3;

    typedef logic [COH_MSG_W-1:0]     coh_msg_t;
    typedef logic [HPROT_W-1:0]       hprot_t;
    typedef logic [LINE_ADDR_W-1:0]   line_addr_t;
    typedef logic [LINE_W-1:0]        line_t;
    typedef logic [CACHE_ID_W-1:0]    cache_id_t;
    typedef logic [WORD_OFFSET_W-1:0] word_offset_t;
    typedef logic [WORD_MASK_W-1:0]   word_mask_t;
    typedef logic [INVACK_CNT_W-1:0]  invack_cnt_t;
    typedef logic [HSIZE_W-1:0]       hsize_t;

    // Payload field order, most significant field first

    // Cache and DMA requests
    // {coh_msg, hprot, addr, line, req_id, word_offset, valid_words}
    localparam int REQ_IN_W = COH_MSG_W + HPROT_W + LINE_ADDR_W + LINE_W
                            + CACHE_ID_W + WORD_OFFSET_W + WORD_MASK_W;

    // Coherence responses
    // {coh_msg, addr, line, req_id}
    localparam int RSP_IN_W = COH_MSG_W + LINE_ADDR_W + LINE_W + CACHE_ID_W;

    // Memory responses carry the line only
    localparam int MEM_RSP_W = LINE_W;

    // Cache and DMA responses
    // {coh_msg, addr, line, invack_cnt, req_id, dest_id, word_offset}
    localparam int RSP_OUT_W = COH_MSG_W + LINE_ADDR_W + LINE_W + INVACK_CNT_W
                             + 2 * CACHE_ID_W + WORD_OFFSET_W;

    // Forwards
    // {coh_msg, addr, req_id, dest_id}
    localparam int FWD_OUT_W = COH_MSG_W + LINE_ADDR_W + 2 * CACHE_ID_W;

    // Memory requests, hwrite is a single bit
    // {hwrite, hsize, hprot, addr, line}
    localparam int MEM_REQ_W = 1 + HSIZE_W + HPROT_W + LINE_ADDR_W + LINE_W;

    typedef logic [REQ_IN_W-1:0]  req_in_payload_t;
    typedef logic [RSP_IN_W-1:0]  rsp_in_payload_t;
    typedef logic [MEM_RSP_W-1:0] mem_rsp_payload_t;
    typedef logic [RSP_OUT_W-1:0] rsp_out_payload_t;
    typedef logic [FWD_OUT_W-1:0] fwd_out_payload_t;
    typedef logic [MEM_REQ_W-1:0] mem_req_payload_t;

    // Skid buffer occupancy
    typedef enum logic {
        SKID_EMPTY = 1'b0,
        SKID_HELD  = 1'b1
    } skid_state_t;

endpackage
